// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wordcopy
SEED      ?= 35164
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' files.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
verilog/wordcopy_pkg.sv
verilog/copy_cfg_if.sv
verilog/mem_cmd_if.sv
verilog/csr_decode.sv
verilog/copy_sequencer.sv
verilog/bus_master.sv
verilog/wordcopy.sv
verification/sdram_model.sv
verification/tb_wordcopy.sv

// File: verification/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
    parameter integer SEED = 32'h895c
) (
    input  logic                clk,
    input  logic                rst_n,
    input  wordcopy_pkg::word_t address,
    input  logic                read,
    input  logic                write,
    input  wordcopy_pkg::word_t writedata,
    output logic                waitrequest,
    output logic                readdatavalid,
    output wordcopy_pkg::word_t readdata
);
    import wordcopy_pkg::*;

    localparam int MEM_WORDS = 1024;  // 4 KiB from address 0

    word_t       mem [MEM_WORDS];
    integer      seed;
    integer      write_count;       // accepted writes since reset
    integer      protocol_errors;
    logic [2:0]  rd_delay;          // cycles left until read data returns
    word_t       rd_addr;
    logic        held;              // last cycle had a command stalled by waitrequest
    word_t       held_addr;
    word_t       held_wdata;
    logic        held_read;
    logic        held_write;
    logic [31:0] rnd;
    logic        accept;

    function automatic word_t fill_value(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a3c_0f96;  // every address bit matters
    endfunction

    initial
    begin
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = fill_value(word_t'(i) << 2);
        end
    end

    assign accept = (read || write) && !waitrequest;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            waitrequest     <= 1'b0;
            readdatavalid   <= 1'b0;
            readdata        <= '0;
            rd_delay        <= '0;
            rd_addr         <= '0;
            held            <= 1'b0;
            write_count     = 0;
            protocol_errors = 0;
        end
        else
        begin
            rnd = $random(seed);
            waitrequest   <= (rnd[1:0] == 2'b00);  // stall about one cycle in four
            readdatavalid <= 1'b0;
            if (rd_delay != 3'd0)
            begin
                rd_delay <= rd_delay - 3'd1;
                if (rd_delay == 3'd1)
                begin
                    readdatavalid <= 1'b1;
                    readdata      <= mem[rd_addr[11:2]];
                end
            end
            if (read && write)
            begin
                protocol_errors = protocol_errors + 1;
                $display("memory model at %0t: read and write asserted together", $time);
            end
            if (held && (address != held_addr || read != held_read || write != held_write
                         || (write && writedata != held_wdata)))
            begin
                protocol_errors = protocol_errors + 1;
                $display("memory model at %0t: command changed while waitrequest was high",
                         $time);
            end
            if (accept && (address[31:12] != '0 || address[1:0] != 2'b00))
            begin
                protocol_errors = protocol_errors + 1;
                $display("memory model at %0t: address %08h is unaligned or outside memory",
                         $time, address);
            end
            else if (accept && read)
            begin
                if (rd_delay != 3'd0)
                begin
                    protocol_errors = protocol_errors + 1;
                    $display("memory model at %0t: read issued while another read is owed",
                             $time);
                end
                rnd = $random(seed);
                rd_addr  <= address;
                rd_delay <= {1'b0, rnd[1:0]} + 3'd1;  // 1 to 4 cycles
            end
            else if (accept && write)
            begin
                mem[address[11:2]] = writedata;
                write_count        = write_count + 1;
            end
            held       <= (read || write) && waitrequest;
            held_addr  <= address;
            held_wdata <= writedata;
            held_read  <= read;
            held_write <= write;
        end
    end

endmodule

// File: verification/tb_wordcopy.sv
`timescale 1ns/1ps

module tb_wordcopy #(
    parameter integer SEED = 32'h895c
);
    import wordcopy_pkg::*;

    localparam int HALF_PERIOD  = 4;  // 8 ns clock
    localparam int RESET_CYCLES = 8;
    localparam int MEM_WORDS    = 1024;
    localparam int N_CASES      = 5;

    typedef struct packed {
        word_t  src;
        word_t  dst;
        count_t count;
        logic   load_cfg;       // write offsets 1 to 3 before the start
        count_t expect_copied;  // status read result
    } copy_case_t;

    // src, dst, count, load_cfg, expected status
    localparam copy_case_t CASES [N_CASES] = '{
        '{32'h0000_0100, 32'h0000_0800, 32'd1,  1'b1, 32'd1},
        '{32'h0000_0200, 32'h0000_0900, 32'd16, 1'b1, 32'd16},
        '{32'h0000_0300, 32'h0000_0a00, 32'd0,  1'b1, 32'd0},
        '{32'h0000_0040, 32'h0000_0c04, 32'd37, 1'b1, 32'd37},
        '{32'h0000_0040, 32'h0000_0c04, 32'd37, 1'b0, 32'd37}  // same settings again
    };

    logic        clk = 1'b0;
    logic        rst_n;
    csr_offset_t slave_address;
    logic        slave_read;
    logic        slave_write;
    word_t       slave_writedata;
    logic        slave_waitrequest;
    word_t       slave_readdata;
    logic        master_waitrequest;
    logic        master_readdatavalid;
    word_t       master_readdata;
    word_t       master_address;
    logic        master_read;
    logic        master_write;
    word_t       master_writedata;

    word_t  shadow [MEM_WORDS];  // expected memory contents
    integer errors;

    wordcopy #(
        .ADDR_STRIDE (DEFAULT_STRIDE)
    ) i_wordcopy (
        .clk                  (clk),
        .rst_n                (rst_n),
        .slave_address        (slave_address),
        .slave_read           (slave_read),
        .slave_write          (slave_write),
        .slave_writedata      (slave_writedata),
        .slave_waitrequest    (slave_waitrequest),
        .slave_readdata       (slave_readdata),
        .master_waitrequest   (master_waitrequest),
        .master_readdatavalid (master_readdatavalid),
        .master_readdata      (master_readdata),
        .master_address       (master_address),
        .master_read          (master_read),
        .master_write         (master_write),
        .master_writedata     (master_writedata)
    );

    sdram_model #(
        .SEED (SEED)
    ) i_sdram_model (
        .clk           (clk),
        .rst_n         (rst_n),
        .address       (master_address),
        .read          (master_read),
        .write         (master_write),
        .writedata     (master_writedata),
        .waitrequest   (master_waitrequest),
        .readdatavalid (master_readdatavalid),
        .readdata      (master_readdata)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic word_t fill_value(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a3c_0f96;  // preload rule of the memory
    endfunction

    function automatic int table_words();
        int n;
        n = 0;
        for (int i = 0; i < N_CASES; i++)
        begin
            n = n + int'(CASES[i].count);
        end
        return n;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;  // inputs change 1 ns after the edge
    endtask

    task automatic csr_write(input csr_offset_t ofs, input word_t data);
        logic stalled;
        slave_address   = ofs;
        slave_writedata = data;
        slave_write     = 1'b1;
        do
        begin
            stalled = slave_waitrequest;  // only depends on engine state
            next_cycle();
        end
        while (stalled);
        slave_write = 1'b0;
    endtask

    task automatic csr_read(input csr_offset_t ofs, output word_t data);
        logic stalled;
        slave_address = ofs;
        slave_read    = 1'b1;
        do
        begin
            stalled = slave_waitrequest;
            data    = slave_readdata;
            next_cycle();
        end
        while (stalled);
        slave_read = 1'b0;
    endtask

    task automatic apply_copy_to_shadow(input copy_case_t c);
        int s;
        int d;
        s = int'(c.src >> 2);
        d = int'(c.dst >> 2);
        for (int i = 0; i < int'(c.count); i++)
        begin
            shadow[d + i] = shadow[s + i];  // word by word, lowest address first
        end
    endtask

    task automatic check_memory(input int idx);
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            if (i_sdram_model.mem[k] !== shadow[k])
            begin
                errors++;
                $display("ERROR @%0t: case %0d word at %08h is %08h, expected %08h",
                         $time, idx, k * 4, i_sdram_model.mem[k], shadow[k]);
            end
        end
    endtask

    task automatic run_case(input int idx);
        copy_case_t c;
        integer     writes_before;
        word_t      status;
        c             = CASES[idx];
        writes_before = i_sdram_model.write_count;
        if (c.load_cfg)
        begin
            csr_write(OFS_DST, c.dst);
            csr_write(OFS_SRC, c.src);
            csr_write(OFS_COUNT, c.count);
        end
        csr_write(OFS_START, 32'd0);
        csr_read(OFS_START, status);  // stalls until the copy is done
        if (status !== c.expect_copied)
        begin
            errors++;
            $display("ERROR @%0t: case %0d status read %0d, expected %0d",
                     $time, idx, status, c.expect_copied);
        end
        apply_copy_to_shadow(c);
        if (i_sdram_model.write_count - writes_before != int'(c.count))
        begin
            errors++;
            $display("ERROR @%0t: case %0d made %0d memory writes, expected %0d",
                     $time, idx, i_sdram_model.write_count - writes_before, c.count);
        end
        check_memory(idx);  // covers range edges and the source too
    endtask

    initial
    begin
        errors          = 0;
        rst_n           = 1'b0;
        slave_address   = OFS_START;
        slave_read      = 1'b0;
        slave_write     = 1'b0;
        slave_writedata = '0;
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            shadow[k] = fill_value(word_t'(k) << 2);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        if (master_read !== 1'b0 || master_write !== 1'b0 || slave_waitrequest !== 1'b0)
        begin
            errors++;
            $display("ERROR @%0t: outputs not idle after reset (read %b write %b wait %b)",
                     $time, master_read, master_write, slave_waitrequest);
        end
        for (int idx = 0; idx < N_CASES; idx++)
        begin
            run_case(idx);
        end
        $display("summary: %0d data errors, %0d memory protocol errors",
                 errors, i_sdram_model.protocol_errors);
        if (errors == 0 && i_sdram_model.protocol_errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    // run length bound from the number of words in the table
    initial
    begin
        int limit;
        limit = 40 * table_words() + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the copy sequence did not complete",
                 limit);
        $display("Something failed");
        $finish;
    end

endmodule

// File: verilog/bus_master.sv
`timescale 1ns/1ps

module bus_master (
    input  logic                clk,
    input  logic                rst_n,
    mem_cmd_if.port             mem,
    input  logic                master_waitrequest,
    input  logic                master_readdatavalid,
    input  wordcopy_pkg::word_t master_readdata,
    output wordcopy_pkg::word_t master_address,
    output wordcopy_pkg::word_t master_writedata,
    output logic                master_read,
    output logic                master_write
);
    import wordcopy_pkg::*;

    logic rd_pending;  // a read was accepted and its data is still owed
    logic cmd_valid;

    // command goes straight out, the requester holds it under waitrequest
    assign master_address   = mem.addr;
    assign master_writedata = mem.wdata;
    assign master_read      = mem.rd_req;
    assign master_write     = mem.wr_req;

    assign cmd_valid    = mem.rd_req || mem.wr_req;
    assign mem.accepted = cmd_valid && !master_waitrequest;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_pending <= 1'b0;
        end
        else if (mem.rd_req && mem.accepted)
        begin
            rd_pending <= 1'b1;
        end
        else if (master_readdatavalid)
        begin
            rd_pending <= 1'b0;
        end
    end

    assign mem.rdata_valid = master_readdatavalid && rd_pending;  // stray pulses dropped
    assign mem.rdata       = master_readdata;

    // a stalled command must not move until the slave takes it
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd_valid && master_waitrequest)
            |=> $stable(master_address) && $stable(master_read)
                && $stable(master_write) && $stable(master_writedata)
    );

    a_rdata_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        master_readdatavalid |-> rd_pending
    );

endmodule

// File: verilog/copy_cfg_if.sv
`timescale 1ns/1ps

interface copy_cfg_if;
    import wordcopy_pkg::*;

    word_t  dst_addr;      // destination start address
    word_t  src_addr;      // source start address
    count_t word_count;    // words requested
    logic   start;         // one-cycle start pulse
    logic   release_done;  // status read seen, back to idle
    logic   busy;          // copy in progress
    logic   done;          // copy finished, result waiting
    count_t copied;        // words finished so far

    modport decoder (
        output dst_addr, src_addr, word_count, start, release_done,
        input  busy, done, copied
    );

    modport sequencer (
        input  dst_addr, src_addr, word_count, start, release_done,
        output busy, done, copied
    );

endinterface

// File: verilog/copy_sequencer.sv
`timescale 1ns/1ps

module copy_sequencer #(
    parameter wordcopy_pkg::word_t ADDR_STRIDE = wordcopy_pkg::DEFAULT_STRIDE
) (
    input  logic          clk,
    input  logic          rst_n,
    copy_cfg_if.sequencer cfg,
    mem_cmd_if.requester  mem
);
    import wordcopy_pkg::*;

    copy_state_t state;
    copy_state_t state_next;
    word_t       src_ptr;     // working source address
    word_t       dst_ptr;     // working destination address
    word_t       word_buf;    // word between read and write
    count_t      copied_q;
    count_t      copied_inc;
    logic        word_done;   // write of the current word accepted
    logic        last_word;

    assign copied_inc = copied_q + count_t'(1);
    assign word_done  = (state == ST_WRITE_REQ) && mem.accepted;
    assign last_word  = (copied_inc == cfg.word_count);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (cfg.start)
                begin
                    // a zero count finishes without touching the bus
                    state_next = (cfg.word_count == '0) ? ST_DONE : ST_READ_REQ;
                end
            end
            ST_READ_REQ:
            begin
                if (mem.accepted)
                begin
                    state_next = ST_READ_WAIT;
                end
            end
            ST_READ_WAIT:
            begin
                if (mem.rdata_valid)
                begin
                    state_next = ST_WRITE_REQ;
                end
            end
            ST_WRITE_REQ:
            begin
                if (mem.accepted)
                begin
                    state_next = last_word ? ST_DONE : ST_READ_REQ;
                end
            end
            ST_DONE:
            begin
                if (cfg.release_done)
                begin
                    state_next = ST_IDLE;
                end
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            copied_q <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == ST_IDLE && cfg.start)
            begin
                copied_q <= '0;
            end
            else if (word_done)
            begin
                copied_q <= copied_inc;
            end
        end
    end

    // address walk and data buffer
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && cfg.start)
        begin
            src_ptr <= cfg.src_addr;
            dst_ptr <= cfg.dst_addr;
        end
        else if (word_done)
        begin
            src_ptr <= src_ptr + ADDR_STRIDE;
            dst_ptr <= dst_ptr + ADDR_STRIDE;
        end
        if (state == ST_READ_WAIT && mem.rdata_valid)
        begin
            word_buf <= mem.rdata;
        end
    end

    assign mem.rd_req = (state == ST_READ_REQ);
    assign mem.wr_req = (state == ST_WRITE_REQ);
    assign mem.addr   = (state == ST_WRITE_REQ) ? dst_ptr : src_ptr;
    assign mem.wdata  = word_buf;

    assign cfg.busy   = (state == ST_READ_REQ) || (state == ST_READ_WAIT)
                        || (state == ST_WRITE_REQ);
    assign cfg.done   = (state == ST_DONE);
    assign cfg.copied = copied_q;

    // count setting frozen during a copy, word counter never runs past it
    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg.busy |-> $stable(cfg.word_count) && (copied_q < cfg.word_count)
    );

endmodule

// File: verilog/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  wordcopy_pkg::csr_offset_t slave_address,
    input  logic                      slave_write,
    input  logic                      slave_read,
    input  wordcopy_pkg::word_t       slave_writedata,
    output logic                      slave_waitrequest,
    output wordcopy_pkg::word_t       slave_readdata,
    copy_cfg_if.decoder               cfg
);
    import wordcopy_pkg::*;

    word_t  dst_q;
    word_t  src_q;
    count_t count_q;
    logic   wr_accept;
    logic   idle;

    assign slave_waitrequest = cfg.busy;  // stalls the cpu for the whole copy
    assign wr_accept         = slave_write && !slave_waitrequest;
    assign idle              = !cfg.busy && !cfg.done;

    // settings registers, kept across copies
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dst_q   <= '0;
            src_q   <= '0;
            count_q <= '0;
        end
        else if (wr_accept)
        begin
            case (slave_address)
                OFS_DST:
                begin
                    dst_q <= slave_writedata;
                end
                OFS_SRC:
                begin
                    src_q <= slave_writedata;
                end
                OFS_COUNT:
                begin
                    count_q <= slave_writedata;
                end
                default:
                begin
                    dst_q <= dst_q;  // offset 0 is the start strobe, no storage
                end
            endcase
        end
    end

    assign cfg.dst_addr   = dst_q;
    assign cfg.src_addr   = src_q;
    assign cfg.word_count = count_q;

    // start only from a clean idle, a start write during ST_DONE is dropped
    assign cfg.start = wr_accept && (slave_address == OFS_START) && idle;

    // the stalled status read completes once the sequencer reaches ST_DONE
    assign cfg.release_done = slave_read && (slave_address == OFS_START) && cfg.done;

    assign slave_readdata = cfg.copied;  // only offset 0 is readable

    // the sequencer leaves idle on the edge after a start
    a_start_leaves_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg.start |=> (cfg.busy || cfg.done)
    );

endmodule

// File: verilog/mem_cmd_if.sv
`timescale 1ns/1ps

interface mem_cmd_if;
    import wordcopy_pkg::*;

    logic  rd_req;       // read command, held until accepted
    logic  wr_req;       // write command, held until accepted
    word_t addr;         // byte address of the command
    word_t wdata;        // write data
    logic  accepted;     // command left the port this cycle
    logic  rdata_valid;  // read data returned this cycle
    word_t rdata;        // returned read data

    modport requester (
        output rd_req, wr_req, addr, wdata,
        input  accepted, rdata_valid, rdata
    );

    modport port (
        input  rd_req, wr_req, addr, wdata,
        output accepted, rdata_valid, rdata
    );

endinterface

// File: verilog/wordcopy.sv
`timescale 1ns/1ps

module wordcopy #(
    parameter wordcopy_pkg::word_t ADDR_STRIDE = wordcopy_pkg::DEFAULT_STRIDE
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // cpu side
    input  wordcopy_pkg::csr_offset_t slave_address,
    input  logic                      slave_read,
    input  logic                      slave_write,
    input  wordcopy_pkg::word_t       slave_writedata,
    output logic                      slave_waitrequest,
    output wordcopy_pkg::word_t       slave_readdata,
    // memory side
    input  logic                      master_waitrequest,
    input  logic                      master_readdatavalid,
    input  wordcopy_pkg::word_t       master_readdata,
    output wordcopy_pkg::word_t       master_address,
    output logic                      master_read,
    output logic                      master_write,
    output wordcopy_pkg::word_t       master_writedata
);

    copy_cfg_if cfg_if ();
    mem_cmd_if  mem_if ();

    csr_decode i_csr_decode (
        .clk               (clk),
        .rst_n             (rst_n),
        .slave_address     (slave_address),
        .slave_write       (slave_write),
        .slave_read        (slave_read),
        .slave_writedata   (slave_writedata),
        .slave_waitrequest (slave_waitrequest),
        .slave_readdata    (slave_readdata),
        .cfg               (cfg_if.decoder)
    );

    copy_sequencer #(
        .ADDR_STRIDE (ADDR_STRIDE)
    ) i_copy_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg_if.sequencer),
        .mem   (mem_if.requester)
    );

    bus_master i_bus_master (
        .clk                  (clk),
        .rst_n                (rst_n),
        .mem                  (mem_if.port),
        .master_waitrequest   (master_waitrequest),
        .master_readdatavalid (master_readdatavalid),
        .master_readdata      (master_readdata),
        .master_address       (master_address),
        .master_writedata     (master_writedata),
        .master_read          (master_read),
        .master_write         (master_write)
    );

endmodule

// File: verilog/wordcopy_pkg.sv
package wordcopy_pkg;

    typedef logic [31:0] word_t;        // data word or byte address
    typedef logic [31:0] count_t;       // number of words
    typedef logic [1:0]  csr_offset_t;  // slave register offset

    // slave register map
    localparam csr_offset_t OFS_START = 2'd0;  // write starts, read returns copied count
    localparam csr_offset_t OFS_DST   = 2'd1;  // destination byte address
    localparam csr_offset_t OFS_SRC   = 2'd2;  // source byte address
    localparam csr_offset_t OFS_COUNT = 2'd3;  // words to copy

    // one word per read/write pair on the master port
    typedef enum logic [2:0] {
        ST_IDLE,       // waiting for a start write
        ST_READ_REQ,   // read command out, waiting for acceptance
        ST_READ_WAIT,  // waiting for readdatavalid
        ST_WRITE_REQ,  // write command out, waiting for acceptance
        ST_DONE        // holding the result until the status read
    } copy_state_t;

    localparam word_t DEFAULT_STRIDE = 32'd4;  // bytes per 32-bit word

endpackage
